// File: bench/memCases.txt
# name op addr data stall, addr and data in hex, stall is the expected miss flag
# op R reads and expects data, W writes data, H is a read held off by halt
coldRead     R 00000100 00000100 1
readHit      R 00000104 00000104 0
writeHit     W 00000108 cafe0001 0
readBack     R 00000108 cafe0001 0
evictRead    R 00000508 00000508 1
writtenBack  R 00000108 cafe0001 1
writeMiss    W 000002c0 12345678 1
allocRead    R 000002c0 12345678 0
neighborRead R 000002fc 000002fc 0
dirtyWrMiss  W 00000ac0 deadbeef 1
oldBlkRead   R 000002c0 12345678 1
newBlkRead   R 00000ac0 deadbeef 1
haltRead     H 00000340 00000340 1
afterHalt    R 00000344 00000344 0

// File: tb.f
hw/memPkg.sv
hw/dataCache.sv
hw/memoryStage.sv
hw/memoryController.sv
hw/memSubsystem.sv
bench/memSubsystemTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP := memSubsystemTb
FILELIST := tb.f
OBJDIR := obj_dir
PASS_MSG := Test completed successfully

SIM := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: bench/memSubsystemTb.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystemTb
    import memPkg::*;
();

    localparam int doneTimeout = 100;
    localparam int haltCycles = 20;
    // Drive edge plus the single READ or WRITE cycle of a hit
    localparam int hitLatency = 2;

    logic                 clk;
    logic                 rst;
    logic [wordWidth-1:0] aluResult;
    logic [wordWidth-1:0] read2Data;
    logic                 memRead;
    logic                 memWrite;
    logic                 halt;
    logic [wordWidth-1:0] memoryOut;
    logic                 accessDone;
    logic                 stallDMAMem;

    int errorCount;
    int testCount;
    int passCount;
    bit aborted;

    memSubsystem memSubsystem_i (
        .clk         (clk),
        .rst         (rst),
        .aluResult   (aluResult),
        .read2Data   (read2Data),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .halt        (halt),
        .memoryOut   (memoryOut),
        .accessDone  (accessDone),
        .stallDMAMem (stallDMAMem)
    );

    always begin
        #2 clk = ~clk;
    end

    task automatic checkWord(input string name, input logic [wordWidth-1:0] expected,
                             input logic [wordWidth-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s memoryOut expected %h actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s stall expected %b actual %b", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[FAIL] %s latency expected %0d actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    // Sample on falling edges, well away from the DUT's rising-edge updates
    task automatic waitDone(input string name, output int cycles, output logic sawStall,
                            output logic [wordWidth-1:0] readValue);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        sawStall = 1'b0;
        readValue = '0;
        cycles = -1;
        while (!seen && n < doneTimeout) begin
            @(negedge clk);
            n++;
            if (stallDMAMem) begin
                sawStall = 1'b1;
            end
            if (accessDone) begin
                seen = 1'b1;
                readValue = memoryOut;
            end
        end
        if (seen) begin
            cycles = n;
        end else begin
            $display("Test %s timed out waiting for accessDone after %0d cycles",
                     name, doneTimeout);
            errorCount++;
            aborted = 1'b1;
        end
    endtask

    // Nothing may start or stall while halt is high
    task automatic holdUnderHalt(input string name);
        int n;
        n = 0;
        while (n < haltCycles) begin
            @(negedge clk);
            n++;
            if (accessDone || stallDMAMem) begin
                $display("Test %s saw activity in cycle %0d while halt was high", name, n);
                errorCount++;
            end
        end
        $display("%s: no accessDone for %0d cycles under halt, timeout as expected",
                 name, haltCycles);
    endtask

    task automatic runCase(input string name, input string op,
                           input logic [wordWidth-1:0] addr,
                           input logic [wordWidth-1:0] data, input logic expMiss);
        int startErrors;
        int gap;
        int cycles;
        logic sawStall;
        logic [wordWidth-1:0] readValue;
        startErrors = errorCount;
        testCount++;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);

        @(posedge clk);
        aluResult <= addr;
        read2Data <= data;
        memRead <= (op != "W");
        memWrite <= (op == "W");
        halt <= (op == "H");

        if (op == "H") begin
            holdUnderHalt(name);
            @(posedge clk);
            halt <= 1'b0;
        end

        waitDone(name, cycles, sawStall, readValue);

        // Request drops on the edge that ends the accessDone cycle
        @(posedge clk);
        memRead <= 1'b0;
        memWrite <= 1'b0;

        if (!aborted) begin
            if (op != "W") begin
                checkWord(name, data, readValue);
            end
            checkFlag(name, expMiss, sawStall);
            if (!expMiss) begin
                checkCycles(name, hitLatency, cycles);
            end
        end

        if (errorCount == startErrors) begin
            passCount++;
            $display("%-13s ok", name);
        end else begin
            $display("%-13s wrong", name);
        end
    endtask

    initial begin
        int fd;
        int fields;
        string line;
        string name;
        string op;
        logic [wordWidth-1:0] addr;
        logic [wordWidth-1:0] data;
        logic expMiss;

        clk = 1'b0;
        rst = 1'b1;
        aluResult = '0;
        read2Data = '0;
        memRead = 1'b0;
        memWrite = 1'b0;
        halt = 1'b0;
        errorCount = 0;
        testCount = 0;
        passCount = 0;
        aborted = 1'b0;
        void'($urandom(32'h36ef));

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("bench/memCases.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/memCases.txt for reading");
            errorCount++;
        end else begin
            while (!aborted && !$feof(fd)) begin
                line = "";
                fields = $fgets(line, fd);
                // Skip comment lines, blank lines give too few fields
                if (fields != 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %s %h %h %b", name, op, addr, data, expMiss);
                    if (fields == 5) begin
                        runCase(name, op, addr, data, expMiss);
                    end
                end
            end
            $fclose(fd);
        end

        $display("Tests run %0d, passed %0d, errors %0d", testCount, passCount, errorCount);
        if (errorCount == 0 && testCount > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/memSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystem
    import memPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [wordWidth-1:0] aluResult,
    input  logic [wordWidth-1:0] read2Data,
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic                 halt,
    output logic [wordWidth-1:0] memoryOut,
    output logic                 accessDone,
    output logic                 stallDMAMem
);

    // Stage to controller
    logic                  cacheMiss;
    logic                  cacheEvict;
    memAddrT               mcAddr;
    logic [blockWidth-1:0] mcDataOut;

    // Controller to stage
    logic [blockWidth-1:0] mcDataIn;
    logic                  mcDataValid;
    logic                  evictDone;

    memoryStage memoryStage_i (
        .clk         (clk),
        .rst         (rst),
        .aluResult   (aluResult),
        .read2Data   (read2Data),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .halt        (halt),
        .mcDataValid (mcDataValid),
        .evictDone   (evictDone),
        .mcDataIn    (mcDataIn),
        .memoryOut   (memoryOut),
        .accessDone  (accessDone),
        .cacheMiss   (cacheMiss),
        .cacheEvict  (cacheEvict),
        .stallDMAMem (stallDMAMem),
        .mcAddr      (mcAddr),
        .mcDataOut   (mcDataOut)
    );

    memoryController memoryController_i (
        .clk         (clk),
        .rst         (rst),
        .cacheMiss   (cacheMiss),
        .cacheEvict  (cacheEvict),
        .mcAddr      (mcAddr),
        .mcDataOut   (mcDataOut),
        .mcDataIn    (mcDataIn),
        .mcDataValid (mcDataValid),
        .evictDone   (evictDone)
    );

endmodule

`default_nettype wire

// File: hw/memoryController.sv
`timescale 1ns/100ps
`default_nettype none

module memoryController
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cacheMiss,
    input  logic                  cacheEvict,
    input  memAddrT               mcAddr,
    input  logic [blockWidth-1:0] mcDataOut,
    output logic [blockWidth-1:0] mcDataIn,
    output logic                  mcDataValid,
    output logic                  evictDone
);

    logic [blockWidth-1:0] store [memBlocks];

    logic [latCountWidth-1:0]  latCount;
    logic [blockAddrWidth-1:0] blkNum;
    logic                      busy;
    logic                      pulsing;
    logic                      respond;

    // Block number from tag and index, wrapped to the store size
    assign blkNum = blockAddrWidth'({mcAddr.fields.tag, mcAddr.fields.index});

    assign busy = cacheMiss || cacheEvict;
    assign pulsing = mcDataValid || evictDone;

    // Last counting cycle, the response shows up on the next one
    assign respond = busy && !pulsing && (latCount == latCountWidth'(memLatency - 1));

    // Every word starts out holding its own byte address
    initial begin
        for (int b = 0; b < memBlocks; b++) begin
            for (int w = 0; w < wordsPerBlock; w++) begin
                store[b][w*wordWidth +: wordWidth] =
                    wordWidth'(b * (blockWidth / 8) + w * (wordWidth / 8));
            end
        end
    end

    // Counter holds at zero through the pulse cycle, so a miss that
    // follows an eviction directly still gets the full latency
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            latCount <= '0;
        end else if (!busy || pulsing || respond) begin
            latCount <= '0;
        end else begin
            latCount <= latCount + latCountWidth'(1);
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            mcDataValid <= 1'b0;
            evictDone <= 1'b0;
        end else begin
            evictDone <= respond && cacheEvict;
            mcDataValid <= respond && !cacheEvict && cacheMiss;
        end
    end

    // Eviction write-back
    always @(posedge clk) begin
        if (respond && cacheEvict) begin
            store[blkNum] <= mcDataOut;
        end
    end

    // Fill data, valid in the same cycle as mcDataValid
    always_ff @(posedge clk) begin
        if (respond && !cacheEvict) begin
            mcDataIn <= store[blkNum];
        end
    end

endmodule

`default_nettype wire

// File: hw/memoryStage.sv
`timescale 1ns/100ps
`default_nettype none

module memoryStage
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [wordWidth-1:0]  aluResult,
    input  logic [wordWidth-1:0]  read2Data,
    input  logic                  memRead,
    input  logic                  memWrite,
    input  logic                  halt,
    input  logic                  mcDataValid,
    input  logic                  evictDone,
    input  logic [blockWidth-1:0] mcDataIn,
    output logic [wordWidth-1:0]  memoryOut,
    output logic                  accessDone,
    output logic                  cacheMiss,
    output logic                  cacheEvict,
    output logic                  stallDMAMem,
    output memAddrT               mcAddr,
    output logic [blockWidth-1:0] mcDataOut
);

    typedef enum logic [3:0] {
        IDLE, READ, EVICT_RD, LOAD_RD, WAIT_RD,
        WRITE, EVICT_WR, LOAD_WR, WAIT_WR
    } stateT;

    stateT currState;
    stateT nextState;

    memAddrT reqAddr;

    // Cache control
    logic                  cacheEnable;
    logic                  cacheRead;
    logic                  cacheWrite;
    logic                  cacheLoad;
    memAddrT               cacheAddr;
    logic [wordWidth-1:0]  cacheDataIn;
    logic [blockWidth-1:0] cacheBlkIn;

    // Cache results
    logic [wordWidth-1:0]  cacheDataOut;
    logic                  cacheHit;
    logic                  lookupMiss;
    logic                  lookupEvict;
    logic [blockWidth-1:0] cacheBlkOut;
    logic [tagWidth-1:0]   victimTag;

    assign reqAddr.raw = aluResult;

    dataCache dataCache_i (
        .clk       (clk),
        .rst       (rst),
        .en        (cacheEnable),
        .rd        (cacheRead),
        .wr        (cacheWrite),
        .ld        (cacheLoad),
        .addr      (cacheAddr),
        .blkIn     (cacheBlkIn),
        .dataIn    (cacheDataIn),
        .dataOut   (cacheDataOut),
        .hit       (cacheHit),
        .miss      (lookupMiss),
        .evict     (lookupEvict),
        .blkOut    (cacheBlkOut),
        .victimTag (victimTag)
    );

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            currState <= IDLE;
        end else begin
            currState <= nextState;
        end
    end

    always_comb begin
        nextState = currState;
        memoryOut = '0;
        accessDone = 1'b0;
        cacheMiss = 1'b0;
        cacheEvict = 1'b0;
        stallDMAMem = 1'b0;
        mcAddr.raw = '0;
        mcDataOut = '0;
        cacheEnable = 1'b0;
        cacheRead = 1'b0;
        cacheWrite = 1'b0;
        cacheLoad = 1'b0;
        cacheAddr.raw = '0;
        cacheDataIn = '0;
        cacheBlkIn = '0;

        case (currState)
            IDLE: begin
                // Reads win over writes, nothing starts while halted
                if (!halt && memRead) begin
                    nextState = READ;
                end else if (!halt && memWrite) begin
                    nextState = WRITE;
                end
            end
            READ, WRITE: begin
                cacheEnable = 1'b1;
                cacheAddr = reqAddr;
                cacheRead = (currState == READ);
                cacheWrite = (currState == WRITE);
                cacheDataIn = read2Data;
                memoryOut = cacheDataOut;
                if (cacheHit) begin
                    accessDone = 1'b1;
                    nextState = IDLE;
                end else if (lookupMiss) begin
                    if (currState == READ) begin
                        nextState = lookupEvict ? EVICT_RD : LOAD_RD;
                    end else begin
                        nextState = lookupEvict ? EVICT_WR : LOAD_WR;
                    end
                end
            end
            EVICT_RD, EVICT_WR: begin
                cacheAddr = reqAddr;
                cacheEvict = 1'b1;
                stallDMAMem = 1'b1;
                // Victim block address is the old tag at this index
                mcAddr.fields.tag = victimTag;
                mcAddr.fields.index = reqAddr.fields.index;
                mcDataOut = cacheBlkOut;
                if (evictDone) begin
                    nextState = (currState == EVICT_RD) ? LOAD_RD : LOAD_WR;
                end
            end
            LOAD_RD, LOAD_WR: begin
                cacheEnable = 1'b1;
                cacheAddr = reqAddr;
                cacheMiss = 1'b1;
                stallDMAMem = 1'b1;
                mcAddr.fields.tag = reqAddr.fields.tag;
                mcAddr.fields.index = reqAddr.fields.index;
                // Fill lands on the same edge the controller data is valid
                cacheLoad = mcDataValid;
                cacheBlkIn = mcDataIn;
                if (mcDataValid) begin
                    nextState = (currState == LOAD_RD) ? WAIT_RD : WAIT_WR;
                end
            end
            WAIT_RD: begin
                stallDMAMem = 1'b1;
                nextState = READ;
            end
            WAIT_WR: begin
                stallDMAMem = 1'b1;
                nextState = WRITE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/dataCache.sv
`timescale 1ns/100ps
`default_nettype none

module dataCache
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  rd,
    input  logic                  wr,
    input  logic                  ld,
    input  memAddrT               addr,
    input  logic [blockWidth-1:0] blkIn,
    input  logic [wordWidth-1:0]  dataIn,
    output logic [wordWidth-1:0]  dataOut,
    output logic                  hit,
    output logic                  miss,
    output logic                  evict,
    output logic [blockWidth-1:0] blkOut,
    output logic [tagWidth-1:0]   victimTag
);

    // Line storage, word 0 sits in the low bits of the block
    logic [wordsPerBlock-1:0][wordWidth-1:0] lineData [lineCount];
    logic [tagWidth-1:0] tagStore [lineCount];

    logic [lineCount-1:0] lineValid;
    logic [lineCount-1:0] lineDirty;

    logic [indexWidth-1:0]   idx;
    logic [wordSelWidth-1:0] wordSel;
    logic                    tagMatch;
    logic                    writeHit;
    logic                    blockLoad;

    assign idx = addr.fields.index;
    assign wordSel = addr.fields.wordSel;

    // Combinational lookup
    assign tagMatch = (tagStore[idx] == addr.fields.tag);
    assign hit = en && lineValid[idx] && tagMatch;
    assign miss = en && !hit;

    // A dirty line holding some other block has to go back to memory first
    assign evict = en && lineValid[idx] && lineDirty[idx] && !tagMatch;

    assign dataOut = (en && rd) ? lineData[idx][wordSel] : '0;

    // Victim view of the indexed line
    assign blkOut = lineData[idx];
    assign victimTag = tagStore[idx];

    assign writeHit = en && wr && hit;
    assign blockLoad = en && ld;

    // Line state
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lineValid <= '0;
            lineDirty <= '0;
        end else if (blockLoad) begin
            lineValid[idx] <= 1'b1;
            lineDirty[idx] <= 1'b0;
        end else if (writeHit) begin
            lineDirty[idx] <= 1'b1;
        end
    end

    // Data and tags
    always_ff @(posedge clk) begin
        if (blockLoad) begin
            lineData[idx] <= blkIn;
            tagStore[idx] <= addr.fields.tag;
        end else if (writeHit) begin
            lineData[idx][wordSel] <= dataIn;
        end
    end

endmodule

`default_nettype wire

// File: hw/memPkg.sv
`default_nettype none

package memPkg;

    // Processor word and cache block geometry
    localparam int wordWidth = 32;
    localparam int blockWidth = 512;
    localparam int wordsPerBlock = 16;
    localparam int lineCount = 16;
    localparam int tagWidth = 22;

    localparam int indexWidth = $clog2(lineCount);
    localparam int wordSelWidth = $clog2(wordsPerBlock);

    // Backing store is 4 KB, block numbers wrap at this size
    localparam int memBlocks = 64;
    localparam int blockAddrWidth = $clog2(memBlocks);

    // Cycles from a controller request level to its response pulse
    localparam int memLatency = 4;
    localparam int latCountWidth = $clog2(memLatency);

    // One address word, seen either whole or split for the cache
    typedef union packed {
        logic [wordWidth-1:0] raw;
        struct packed {
            logic [tagWidth-1:0]     tag;
            logic [indexWidth-1:0]   index;
            logic [wordSelWidth-1:0] wordSel;
            logic [1:0]              byteSel;
        } fields;
    } memAddrT;

endpackage

`default_nettype wire
